// ==== rtl/ghash_pkg.sv ====
// GHASH block widths, reduction constant, command opcodes and request/result structs.

package ghash_pkg;

    // Width of one GCM block.
    // Also the width of a GF(2^128) field element.
    localparam int NB_BLOCK = 128;

    // Width of the unreduced carry-less product.
    localparam int NB_PROD = 2*NB_BLOCK-1;

    // Low terms of the field polynomial.
    // x^128 = x^7 + x^2 + x + 1.
    // Bit index equals polynomial degree.
    localparam logic [7:0] GF_POLY_LOW = 8'b1000_0111;

    // Command opcodes.
    typedef enum logic [1:0]
    {
        // Store data as H and zero the hash state.
        CMD_LOAD_H = 2'd0,
        // Zero the hash state and keep H.
        CMD_CLEAR  = 2'd1,
        // Absorb one data block.
        CMD_BLOCK  = 2'd2,
        // Absorb the length block and request a tag.
        CMD_FINISH = 2'd3
    } ghash_cmd_e;

    // One command with its data block.
    typedef struct packed
    {
        ghash_cmd_e          cmd;
        logic [NB_BLOCK-1:0] data;
    } ghash_req_t;

    // Values used only by the finish command.
    typedef struct packed
    {
        // Encrypted pre-counter block E(K,J0).
        logic [NB_BLOCK-1:0] ek_j0;
        // Tag to compare against.
        logic [NB_BLOCK-1:0] tag_exp;
    } gcm_final_t;

    // Computed tag and comparison flag.
    typedef struct packed
    {
        logic [NB_BLOCK-1:0] tag;
        logic                match;
    } gcm_result_t;

endpackage

// ==== rtl/multiplier_without_pipe.sv ====
// Combinational carry-less multiplier using gated partial products and an XOR sum.

`timescale 1ns/1ps

module multiplier_without_pipe
#(
    // Width of each operand.
    parameter int NB_DATA = 64
)
(
    // Outputs.
    output logic [2*NB_DATA-2:0] o_data_z,
    // Inputs.
    input  logic [NB_DATA-1:0]   i_data_x,
    input  logic [NB_DATA-1:0]   i_data_y
);

    // One shifted partial product per bit of x.
    logic [2*NB_DATA-2:0] subprods [NB_DATA];

    genvar ii;

    // Partial product generation.
    // Operand y is gated by bit ii of x.
    // Then shifted up by ii positions.
    generate
        for (ii = 0; ii < NB_DATA; ii++)
        begin : gen_partial_products
            assign subprods[ii]
                = {{(NB_DATA-1){1'b0}}, {NB_DATA{i_data_x[ii]}} & i_data_y} << ii;
        end
    endgenerate

    // Partial product summation.
    // Addition in GF(2) is XOR, no carries.
    always_comb
    begin : l_xor_tree
        o_data_z = '0;
        for (int i = 0; i < NB_DATA; i++)
        begin
            o_data_z = o_data_z ^ subprods[i];
        end
    end

endmodule

// ==== rtl/gf128_multiplier.sv ====
// GF(2^128) multiplier in GCM bit order with two-step polynomial reduction.

`timescale 1ns/1ps

module gf128_multiplier
    import ghash_pkg::*;
(
    input  logic [NB_BLOCK-1:0] i_a,
    input  logic [NB_BLOCK-1:0] i_b,
    output logic [NB_BLOCK-1:0] o_p
);

    // Operands with index equal to degree.
    logic [NB_BLOCK-1:0] a_rev;
    logic [NB_BLOCK-1:0] b_rev;

    // Unreduced carry-less product.
    logic [NB_PROD-1:0]  prod;

    // Coefficients of x^128 and above.
    logic [NB_BLOCK-2:0] prod_hi;

    // After first fold, degree at most 133.
    logic [NB_BLOCK+6:0] fold_1;

    // Leftover coefficients of x^128..x^134.
    logic [6:0]          fold_hi;

    // Fully reduced product, index equals degree.
    logic [NB_BLOCK-1:0] fold_2;

    // GCM puts x^0 in bit 127.
    // Reverse so bit i is the x^i coefficient.
    assign a_rev = {<<{i_a}};
    assign b_rev = {<<{i_b}};

    multiplier_without_pipe
    #(
        .NB_DATA  (NB_BLOCK)
    )
    u_multiplier_without_pipe
    (
        .o_data_z (prod),
        .i_data_x (a_rev),
        .i_data_y (b_rev)
    );

    assign prod_hi = prod[NB_PROD-1:NB_BLOCK];

    // First fold.
    // Each x^(128+k) becomes x^k times the low polynomial.
    always_comb
    begin
        fold_1 = {7'b0, prod[NB_BLOCK-1:0]};
        for (int j = 0; j < 8; j++)
        begin
            if (GF_POLY_LOW[j])
            begin
                fold_1 = fold_1 ^ ({8'b0, prod_hi} << j);
            end
        end
    end

    assign fold_hi = fold_1[NB_BLOCK+6:NB_BLOCK];

    // Second fold.
    // At most degree 6 + 7 here, so no further overflow.
    always_comb
    begin
        fold_2 = fold_1[NB_BLOCK-1:0];
        for (int j = 0; j < 8; j++)
        begin
            if (GF_POLY_LOW[j])
            begin
                fold_2 = fold_2 ^ ({{(NB_BLOCK-7){1'b0}}, fold_hi} << j);
            end
        end
    end

    // Back to GCM bit order.
    assign o_p = {<<{fold_2}};

endmodule

// ==== rtl/ghash_accumulator.sv ====
// GHASH accumulator holding H and the hash state, one hash step per accepted block.

`timescale 1ns/1ps

module ghash_accumulator
    import ghash_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  ghash_req_t          i_req,
    output logic [NB_BLOCK-1:0] o_hash,
    output logic                o_fin_valid,
    output logic [NB_BLOCK-1:0] o_fin_hash
);

    // Hash subkey.
    logic [NB_BLOCK-1:0] h_key;

    // Running hash state Y.
    logic [NB_BLOCK-1:0] y_hash;

    // Multiplier operand and product.
    logic [NB_BLOCK-1:0] mult_a;
    logic [NB_BLOCK-1:0] mult_p;

    // Finish seen on the previous edge.
    logic                fin_valid;

    // Y xor incoming block.
    // Only meaningful for block and finish commands.
    assign mult_a = y_hash ^ i_req.data;

    // Single-cycle field product by H.
    gf128_multiplier
    u_gf128_multiplier
    (
        .i_a (mult_a),
        .i_b (h_key),
        .o_p (mult_p)
    );

    // Command decode and state update.
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            h_key     <= '0;
            y_hash    <= '0;
            fin_valid <= 1'b0;
        end
        else
        begin
            // One-cycle pulse after a finish edge.
            fin_valid <= i_req_valid && (i_req.cmd == CMD_FINISH);

            if (i_req_valid)
            begin
                case (i_req.cmd)
                    CMD_LOAD_H:
                    begin
                        // New key starts a fresh hash.
                        h_key  <= i_req.data;
                        y_hash <= '0;
                    end
                    CMD_CLEAR:
                    begin
                        y_hash <= '0;
                    end
                    CMD_BLOCK, CMD_FINISH:
                    begin
                        // Y = (Y ^ X) * H.
                        y_hash <= mult_p;
                    end
                    default:
                    begin
                        y_hash <= y_hash;
                    end
                endcase
            end
        end
    end

    assign o_hash      = y_hash;
    assign o_fin_valid = fin_valid;

    // Y already holds the finished hash during the pulse.
    assign o_fin_hash  = y_hash;

endmodule

// ==== rtl/gcm_tag_check.sv ====
// GCM tag masking with E(K,J0), tag register and comparison against the expected tag.

`timescale 1ns/1ps

module gcm_tag_check
    import ghash_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  ghash_cmd_e          i_req_cmd,
    input  logic                i_fin_valid,
    input  logic [NB_BLOCK-1:0] i_fin_hash,
    input  gcm_final_t          i_final,
    output logic                o_done,
    output gcm_result_t         o_result
);

    // Final values captured with the finish command.
    gcm_final_t  final_q;

    // Tag and match before the output register.
    gcm_result_t result_d;

    // Capture on the same edge the accumulator accepts the finish.
    always_ff @(posedge i_clock)
    begin
        if (i_req_valid && (i_req_cmd == CMD_FINISH))
        begin
            final_q <= i_final;
        end
    end

    // Tag = GHASH ^ E(K,J0).
    always_comb
    begin
        result_d.tag   = i_fin_hash ^ final_q.ek_j0;
        result_d.match = (result_d.tag == final_q.tag_exp);
    end

    // Result register and done pulse.
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            o_done   <= 1'b0;
            o_result <= '0;
        end
        else
        begin
            o_done <= i_fin_valid;
            // Held until the next finish.
            if (i_fin_valid)
            begin
                o_result <= result_d;
            end
        end
    end

endmodule

// ==== rtl/gcm_auth_top.sv ====
// GCM authentication top connecting the GHASH accumulator and the tag checker.

`timescale 1ns/1ps

module gcm_auth_top
    import ghash_pkg::*;
(
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  ghash_req_t          i_req,
    input  gcm_final_t          i_final,
    output logic                o_done,
    output gcm_result_t         o_result,
    output logic [NB_BLOCK-1:0] o_hash
);

    // Finish pulse and hash from the accumulator.
    logic                fin_valid;
    logic [NB_BLOCK-1:0] fin_hash;

    // Hash state and subkey.
    ghash_accumulator
    u_ghash_accumulator
    (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .o_hash      (o_hash),
        .o_fin_valid (fin_valid),
        .o_fin_hash  (fin_hash)
    );

    // Tag masking and compare.
    // Sees the raw request to capture i_final on the finish edge.
    gcm_tag_check
    u_gcm_tag_check
    (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req_cmd   (i_req.cmd),
        .i_fin_valid (fin_valid),
        .i_fin_hash  (fin_hash),
        .i_final     (i_final),
        .o_done      (o_done),
        .o_result    (o_result)
    );

endmodule

// ==== tb/gcm_auth_props.sv ====
// Bound concurrent assertions on done timing after finish commands and on reset values.

`timescale 1ns/1ps

module gcm_auth_props
    import ghash_pkg::*;
(
    input logic                i_clock,
    input logic                i_rst,
    input logic                i_req_valid,
    input ghash_req_t          i_req,
    input logic                o_done,
    input gcm_result_t         o_result,
    input logic [NB_BLOCK-1:0] o_hash
);

    // Failed assertion count, read by the testbench.
    int unsigned fail_count = 0;

    // Finish command seen on this edge.
    logic finish_req;

    assign finish_req = i_req_valid && (i_req.cmd == CMD_FINISH);

    // Reset edge clears done, result and hash.
    property p_reset_clears;
        @(posedge i_clock) i_rst |=> (!o_done && (o_result == '0) && (o_hash == '0));
    endproperty

    // Done two edges after each finish.
    property p_done_after_finish;
        @(posedge i_clock) disable iff (i_rst) finish_req |-> ##2 o_done;
    endproperty

    // No done without a finish two edges back.
    property p_done_needs_finish;
        @(posedge i_clock) disable iff (i_rst) o_done |-> $past(finish_req, 2);
    endproperty

    a_reset_clears: assert property (p_reset_clears)
    else
    begin
        fail_count++;
        $error("o_done, o_result or o_hash not cleared by reset");
    end

    a_done_after_finish: assert property (p_done_after_finish)
    else
    begin
        fail_count++;
        $error("o_done missing two edges after a finish command");
    end

    a_done_needs_finish: assert property (p_done_needs_finish)
    else
    begin
        fail_count++;
        $error("o_done high without a finish command two edges earlier");
    end

endmodule

bind gcm_auth_top gcm_auth_props u_props
(
    .i_clock     (i_clock),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_done      (o_done),
    .o_result    (o_result),
    .o_hash      (o_hash)
);

// ==== tb/gcm_auth_tb.sv ====
// Testbench for gcm_auth_top with a bit-serial GHASH model, directed and random streams.

`timescale 1ns/1ps

module gcm_auth_tb
    import ghash_pkg::*;
();

    localparam logic [31:0] SEED = 32'h809d7943;
    // Roughly 270 cycles of traffic plus margin for short random streams.
    localparam int MAX_CYCLES = 600;
    localparam int N_RANDOM = 200;

    // GCM spec test case 2.
    localparam logic [NB_BLOCK-1:0] TC2_H   = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
    localparam logic [NB_BLOCK-1:0] TC2_C   = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam logic [NB_BLOCK-1:0] TC2_LEN = 128'h80;
    localparam logic [NB_BLOCK-1:0] TC2_EK  = 128'h58e2fccefa7e3061367f1d57a4e7455a;
    localparam logic [NB_BLOCK-1:0] TC2_TAG = 128'hab6e47d42cec13bdf53a67b21257bddf;

    logic                i_clock;
    logic                i_rst;
    logic                i_req_valid;
    ghash_req_t          i_req;
    gcm_final_t          i_final;
    logic                o_done;
    gcm_result_t         o_result;
    logic [NB_BLOCK-1:0] o_hash;

    // Reference model state.
    logic [NB_BLOCK-1:0] model_h;
    logic [NB_BLOCK-1:0] model_y;
    // Results owed by pending finishes.
    gcm_result_t         exp_q [$];
    int                  cycles = 0;

    gcm_auth_top dut
    (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_final     (i_final),
        .o_done      (o_done),
        .o_result    (o_result),
        .o_hash      (o_hash)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    // Bit-serial GCM multiply.
    // Bit 127 is x^0, so a right shift raises the degree.
    function automatic logic [NB_BLOCK-1:0] gf_mult_ref(input logic [NB_BLOCK-1:0] x,
                                                        input logic [NB_BLOCK-1:0] y);
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        logic [7:0]          r_byte;
        z = '0;
        v = y;
        // Reflected low terms give 8'he1.
        r_byte = {<<{GF_POLY_LOW}};
        for (int i = 0; i < NB_BLOCK; i++)
        begin
            if (x[NB_BLOCK-1-i])
            begin
                z = z ^ v;
            end
            if (v[0])
            begin
                v = (v >> 1) ^ {r_byte, {(NB_BLOCK-8){1'b0}}};
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    function automatic logic [NB_BLOCK-1:0] rand_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("Fail %s got %h expected %h", name, got, exp);
        stop_run();
    endtask

    // Drive one command, step the model, check Y after the edge.
    task automatic send_cmd(input ghash_cmd_e cmd, input logic [NB_BLOCK-1:0] data);
        i_req_valid = 1'b1;
        i_req.cmd   = cmd;
        i_req.data  = data;
        case (cmd)
            CMD_LOAD_H:
            begin
                model_h = data;
                model_y = '0;
            end
            CMD_CLEAR:
            begin
                model_y = '0;
            end
            default:
            begin
                model_y = gf_mult_ref(model_y ^ data, model_h);
            end
        endcase
        @(negedge i_clock);
        assert (o_hash == model_y) else report_mismatch("o_hash", o_hash, model_y);
    endtask

    // Finish with its final values, and queue the expected result.
    task automatic finish_cmd(input logic [NB_BLOCK-1:0] len, input logic [NB_BLOCK-1:0] ek,
                              input logic [NB_BLOCK-1:0] tag_exp);
        gcm_result_t exp;
        i_final.ek_j0   = ek;
        i_final.tag_exp = tag_exp;
        send_cmd(CMD_FINISH, len);
        exp.tag   = model_y ^ ek;
        exp.match = (exp.tag == tag_exp);
        exp_q.push_back(exp);
    endtask

    task automatic go_idle();
        i_req_valid = 1'b0;
        i_req       = '0;
    endtask

    // Poll until the done pulse.
    task automatic wait_done();
        while (!o_done)
        begin
            @(negedge i_clock);
        end
    endtask

    task automatic check_result();
        gcm_result_t exp;
        assert (o_done) else report_error("o_done missing for a pending finish");
        assert (exp_q.size() != 0) else report_error("o_done with no finish pending");
        exp = exp_q.pop_front();
        assert (o_result == exp) else report_mismatch("o_result", o_result, exp);
    endtask

    // Run limit and bound assertion monitor.
    always @(posedge i_clock)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            report_error("Timeout: run exceeded the cycle limit");
        end
        else if (dut.u_props.fail_count != 0)
        begin
            report_error("A bound done timing or reset assertion failed");
        end
    end

    initial
    begin
        logic [NB_BLOCK-1:0] len;
        logic [NB_BLOCK-1:0] ek;
        logic [NB_BLOCK-1:0] tag_exp;
        int                  remaining;
        int                  len_n;
        int                  flip;
        void'($urandom(SEED));
        i_rst       = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_final     = '0;
        model_h     = '0;
        model_y     = '0;
        repeat (4) @(negedge i_clock);
        i_rst = 1'b0;

        // Known vector.
        send_cmd(CMD_LOAD_H, TC2_H);
        send_cmd(CMD_BLOCK, TC2_C);
        finish_cmd(TC2_LEN, TC2_EK, TC2_TAG);
        go_idle();
        wait_done();
        check_result();
        assert (o_result.tag == TC2_TAG)
            else report_mismatch("o_result.tag", o_result.tag, TC2_TAG);
        assert (o_result.match) else report_error("match low for the known test vector");

        // Random streams each opened by a clear.
        send_cmd(CMD_LOAD_H, rand_block());
        remaining = N_RANDOM;
        while (remaining > 0)
        begin
            len_n = 1 + $urandom_range(7);
            if (len_n > remaining)
            begin
                len_n = remaining;
            end
            send_cmd(CMD_CLEAR, '0);
            repeat (len_n) send_cmd(CMD_BLOCK, rand_block());
            remaining -= len_n;
        end

        // Expected tag with one flipped bit.
        len     = rand_block();
        ek      = rand_block();
        tag_exp = gf_mult_ref(model_y ^ len, model_h) ^ ek;
        flip    = $urandom_range(NB_BLOCK-1);
        tag_exp[flip] = ~tag_exp[flip];
        finish_cmd(len, ek, tag_exp);
        go_idle();
        wait_done();
        check_result();
        assert (!o_result.match) else report_error("match high for a corrupted expected tag");

        // Key reload midstream then a clear that keeps H.
        send_cmd(CMD_LOAD_H, rand_block());
        send_cmd(CMD_BLOCK, rand_block());
        send_cmd(CMD_BLOCK, rand_block());
        send_cmd(CMD_LOAD_H, rand_block());
        assert (o_hash == '0) else report_mismatch("o_hash", o_hash, 0);
        send_cmd(CMD_BLOCK, rand_block());
        send_cmd(CMD_BLOCK, rand_block());
        send_cmd(CMD_CLEAR, rand_block());
        assert (o_hash == '0) else report_mismatch("o_hash", o_hash, 0);
        send_cmd(CMD_BLOCK, rand_block());
        send_cmd(CMD_BLOCK, rand_block());

        // Two finishes on consecutive cycles.
        finish_cmd(rand_block(), rand_block(), rand_block());
        len     = rand_block();
        ek      = rand_block();
        tag_exp = gf_mult_ref(model_y ^ len, model_h) ^ ek;
        finish_cmd(len, ek, tag_exp);
        go_idle();
        wait_done();
        check_result();
        @(negedge i_clock);
        check_result();
        assert (o_result.match) else report_error("match low for the second finish");
        @(negedge i_clock);

        if (dut.u_props.fail_count != 0)
        begin
            report_error("A bound done timing or reset assertion failed");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
rtl/ghash_pkg.sv
rtl/multiplier_without_pipe.sv
rtl/gf128_multiplier.sv
rtl/ghash_accumulator.sv
rtl/gcm_tag_check.sv
rtl/gcm_auth_top.sv
tb/gcm_auth_props.sv
tb/gcm_auth_tb.sv

// ==== Bender.yml ====
package:
  name: gcm_auth

sources:
  # Package first, then the RTL in dependency order.
  - rtl/ghash_pkg.sv
  - rtl/multiplier_without_pipe.sv
  - rtl/gf128_multiplier.sv
  - rtl/ghash_accumulator.sv
  - rtl/gcm_tag_check.sv
  - rtl/gcm_auth_top.sv

  # Testbench and bound assertions.
  - target: test
    files:
      - tb/gcm_auth_props.sv
      - tb/gcm_auth_tb.sv
